/* list.f */
design/icache_pkg.sv
design/icache_if.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_refill.sv
design/icache_ctrl.sv
design/icache_top.sv
verif/icache_mem_model.sv
verif/tb_icache.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_icache -f list.f -o sim_icache
out=$(./obj_dir/sim_icache)
echo "$out"
if echo "$out" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1

/* verif/tb_icache.sv */
`timescale 1ns/100ps

module tb_icache;

	localparam int NUM_SETS = 64;
	localparam int NUM_TESTS = 19;
	localparam int MAX_WAIT = 32; // cycles per fetch
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 40;
	localparam icache_pkg::word_t PATTERN = 64'h5a3c_96e1_0f78_c3a5;

	typedef struct packed {
		icache_pkg::addr_t addr;
		logic flush;
		logic refill;
	} fetch_t;

	// set 3 lines are 0x1060, 0x1860 and 0x2060
	localparam fetch_t TESTS [NUM_TESTS] = '{
		'{64'h0000_0000_0000_1000, 1'b0, 1'b1}, // cold miss
		'{64'h0000_0000_0000_1018, 1'b0, 1'b0},
		'{64'h0000_0000_0000_1008, 1'b0, 1'b0},
		'{64'h0000_0000_0000_1060, 1'b0, 1'b1},
		'{64'h0000_0000_0000_1868, 1'b0, 1'b1}, // second way of set 3
		'{64'h0000_0000_0000_1070, 1'b0, 1'b0},
		'{64'h0000_0000_0000_1878, 1'b0, 1'b0},
		'{64'h0000_0000_0000_1060, 1'b0, 1'b0},
		'{64'h0000_0000_0000_2068, 1'b0, 1'b1}, // evicts 0x1860
		'{64'h0000_0000_0000_1078, 1'b0, 1'b0},
		'{64'h0000_0000_0000_1860, 1'b0, 1'b1},
		'{64'h0000_0000_0000_1068, 1'b0, 1'b0},
		'{64'h0000_0000_0000_1010, 1'b1, 1'b1}, // after flush
		'{64'h0000_0000_0000_1060, 1'b0, 1'b1},
		'{64'h0000_0000_0000_1860, 1'b0, 1'b1},
		'{64'h0000_0000_0000_1018, 1'b0, 1'b0},
		'{64'h8000_0000_0000_1040, 1'b0, 1'b1},
		'{64'h0000_0000_0000_1040, 1'b0, 1'b1}, // other tag in set 2
		'{64'h8000_0000_0000_1058, 1'b0, 1'b0}
	};

	logic clk;
	logic rst_n;
	icache_pkg::addr_t cpu_req_addr;
	logic cpu_req_valid;
	icache_pkg::word_t cpu_data_read;
	logic cpu_ready;
	icache_pkg::addr_t mem_req_addr;
	logic mem_req_valid;
	icache_pkg::word_t mem_data_read;
	logic mem_ready;
	logic mem_done;
	logic flush;
	int req_count;
	icache_pkg::addr_t last_req_addr;

	int check_errors = 0;
	int failed_tests = 0;

	// reference cache of line addresses
	icache_pkg::addr_t ref_line [2][NUM_SETS];
	logic ref_valid [2][NUM_SETS];
	logic ref_lru [NUM_SETS]; // most recent way

	icache_top #(.NUM_SETS(NUM_SETS)) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_req_addr(cpu_req_addr),
		.cpu_req_valid(cpu_req_valid),
		.cpu_data_read(cpu_data_read),
		.cpu_ready(cpu_ready),
		.mem_req_addr(mem_req_addr),
		.mem_req_valid(mem_req_valid),
		.mem_data_read(mem_data_read),
		.mem_ready(mem_ready),
		.mem_done(mem_done),
		.flush(flush)
	);

	icache_mem_model #(.PATTERN(PATTERN)) i_mem (
		.clk(clk),
		.rst_n(rst_n),
		.mem_req_addr(mem_req_addr),
		.mem_req_valid(mem_req_valid),
		.mem_data_read(mem_data_read),
		.mem_ready(mem_ready),
		.mem_done(mem_done),
		.req_count(req_count),
		.last_req_addr(last_req_addr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		check_errors++;
	endtask

	task automatic clear_ref_valid();
		for (int s = 0; s < NUM_SETS; s++) begin
			ref_valid[0][s] = 1'b0;
			ref_valid[1][s] = 1'b0;
		end
	endtask

	// lookup plus fill by the victim rule
	task automatic ref_access(input icache_pkg::addr_t addr, output logic hit);
		icache_pkg::addr_t line;
		int set;
		int way;
		line = addr >> icache_pkg::OFFSET_BITS;
		set = int'(line) & (NUM_SETS - 1);
		hit = 1'b0;
		way = 0;
		for (int w = 0; w < 2; w++) begin
			if (ref_valid[w][set] && ref_line[w][set] == line) begin
				hit = 1'b1;
				way = w;
			end
		end
		if (!hit) begin
			if (!ref_valid[0][set])
				way = 0;
			else if (!ref_valid[1][set])
				way = 1;
			else
				way = ref_lru[set] ? 0 : 1;
			ref_valid[way][set] = 1'b1;
			ref_line[way][set] = line;
		end
		ref_lru[set] = (way == 1);
	endtask

	task automatic run_fetch(input int n);
		fetch_t t;
		logic ref_hit;
		int start_count;
		int cycles;
		int errs_before;
		icache_pkg::word_t expected;
		t = TESTS[n];
		errs_before = check_errors;
		if (t.flush) begin
			@(posedge clk);
			flush <= 1'b1;
			@(posedge clk);
			flush <= 1'b0;
			clear_ref_valid();
		end
		ref_access(t.addr, ref_hit);
		assert (t.refill == !ref_hit)
			else report_mismatch($sformatf("table refill flag %0b, reference says %0b",
				t.refill, !ref_hit));
		expected = {t.addr[60:0], t.addr[63:61]} ^ PATTERN; // memory word at this address
		@(posedge clk);
		cpu_req_addr <= t.addr;
		cpu_req_valid <= 1'b1;
		start_count = req_count;
		@(posedge clk); // request sampled here
		cycles = 0;
		while (!cpu_ready && cycles < MAX_WAIT) begin
			@(posedge clk);
			cycles++;
		end
		cpu_req_valid <= 1'b0;
		if (!cpu_ready) begin
			$display("test %0d: cache gave no response within %0d cycles", n, MAX_WAIT);
			check_errors++;
		end else begin
			assert (cpu_data_read == expected)
				else report_mismatch($sformatf("data %h, expected %h", cpu_data_read, expected));
			assert (req_count - start_count == (t.refill ? 1 : 0))
				else report_mismatch($sformatf("%0d line requests, expected %0d",
					req_count - start_count, t.refill ? 1 : 0));
			assert (!mem_req_valid)
				else report_mismatch("mem_req_valid still high at the response");
			if (t.refill) begin
				assert (last_req_addr == (t.addr & ~64'h1f))
					else report_mismatch($sformatf("line request at %h", last_req_addr));
			end else begin
				assert (cycles == 2)
					else report_mismatch($sformatf("hit latency %0d cycles", cycles));
			end
		end
		if (check_errors != errs_before)
			failed_tests++;
		$display("test %0d addr %h %s: %s", n, t.addr, t.refill ? "miss" : "hit",
			check_errors == errs_before ? "ok" : "FAIL");
	endtask

	initial begin
		rst_n = 1'b0;
		cpu_req_addr = '0;
		cpu_req_valid = 1'b0;
		flush = 1'b0;
		clear_ref_valid();
		for (int s = 0; s < NUM_SETS; s++)
			ref_lru[s] = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		for (int n = 0; n < NUM_TESTS; n++)
			run_fetch(n);
		$display("%0d tests run, %0d failed, %0d check errors", NUM_TESTS, failed_tests,
			check_errors);
		if (check_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

/* verif/icache_mem_model.sv */
`timescale 1ns/100ps

module icache_mem_model #(
	parameter icache_pkg::word_t PATTERN = 64'h0
) (
	input logic clk,
	input logic rst_n,
	input icache_pkg::addr_t mem_req_addr,
	input logic mem_req_valid,
	output icache_pkg::word_t mem_data_read,
	output logic mem_ready,
	output logic mem_done,
	output int req_count,
	output icache_pkg::addr_t last_req_addr
);

	integer seed = 32'hef441866;
	logic busy;
	logic [1:0] beat;
	logic [1:0] gap; // idle cycles left before the next beat

	// rotate keeps every address bit in the word
	function automatic icache_pkg::word_t word_at(input icache_pkg::addr_t a);
		return {a[60:0], a[63:61]} ^ PATTERN;
	endfunction

	initial begin
		mem_ready = 1'b0;
		mem_done = 1'b0;
		mem_data_read = '0;
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			beat <= 2'd0;
			gap <= 2'd0;
			mem_ready <= 1'b0;
			mem_done <= 1'b0;
			mem_data_read <= '0;
			req_count <= 0;
			last_req_addr <= '0;
		end else begin
			mem_ready <= 1'b0;
			mem_done <= 1'b0;
			if (busy) begin
				if (gap != 2'd0) begin
					gap <= gap - 2'd1;
				end else begin
					mem_ready <= 1'b1;
					mem_data_read <= word_at({last_req_addr[icache_pkg::ADDR_BITS-1:5], beat, 3'b000});
					mem_done <= (beat == 2'd3);
					beat <= beat + 2'd1;
					gap <= 2'($random(seed));
					if (beat == 2'd3)
						busy <= 1'b0; // burst complete
				end
			end else if (mem_req_valid) begin
				busy <= 1'b1;
				beat <= 2'd0;
				gap <= 2'($random(seed));
				last_req_addr <= mem_req_addr;
				req_count <= req_count + 1;
			end
		end
	end

endmodule

/* design/icache_top.sv */
`timescale 1ns/100ps

module icache_top #(
	parameter int NUM_SETS = 64 // 2 KiB per way
) (
	input logic clk,
	input logic rst_n,
	input icache_pkg::addr_t cpu_req_addr,
	input logic cpu_req_valid,
	output icache_pkg::word_t cpu_data_read,
	output logic cpu_ready,
	output icache_pkg::addr_t mem_req_addr,
	output logic mem_req_valid,
	input icache_pkg::word_t mem_data_read,
	input logic mem_ready,
	input logic mem_done,
	input logic flush
);

	icache_lookup_if #(.NUM_SETS(NUM_SETS)) lookup_bus ();
	icache_fill_if fill_bus ();

	icache_ctrl #(
		.NUM_SETS(NUM_SETS)
	) i_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_req_addr(cpu_req_addr),
		.cpu_req_valid(cpu_req_valid),
		.cpu_data_read(cpu_data_read),
		.cpu_ready(cpu_ready),
		.lookup(lookup_bus.ctrl),
		.fill(fill_bus.ctrl)
	);

	icache_tag_array #(
		.NUM_SETS(NUM_SETS)
	) i_tag_array (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.lookup(lookup_bus.tags),
		.fill_way(fill_bus.fill_way)
	);

	icache_data_array #(
		.NUM_SETS(NUM_SETS)
	) i_data_array (
		.clk(clk),
		.lookup(lookup_bus.data),
		.fill(fill_bus.data)
	);

	icache_refill i_refill (
		.clk(clk),
		.rst_n(rst_n),
		.fill(fill_bus.refill),
		.mem_req_addr(mem_req_addr),
		.mem_req_valid(mem_req_valid),
		.mem_data_read(mem_data_read),
		.mem_ready(mem_ready),
		.mem_done(mem_done)
	);

endmodule

/* design/icache_ctrl.sv */
`timescale 1ns/100ps

module icache_ctrl #(
	parameter int NUM_SETS = 64
) (
	input logic clk,
	input logic rst_n,
	input icache_pkg::addr_t cpu_req_addr,
	input logic cpu_req_valid,
	output icache_pkg::word_t cpu_data_read,
	output logic cpu_ready,
	icache_lookup_if.ctrl lookup,
	icache_fill_if.ctrl fill
);

	localparam int INDEX_BITS = $clog2(NUM_SETS);
	localparam int TAG_LSB = icache_pkg::OFFSET_BITS + INDEX_BITS;

	icache_pkg::cache_state_e state;
	icache_pkg::cache_state_e next_state;
	icache_pkg::addr_t req_addr; // request held for lookup and refill
	icache_pkg::way_t fill_way_q;
	logic req_take;
	logic miss;

	// in the response cycle the core still shows the old request
	assign req_take = cpu_req_valid && !cpu_ready;
	assign miss = (state == icache_pkg::S_LOOKUP) && !lookup.hit;

	assign lookup.index = req_addr[icache_pkg::OFFSET_BITS +: INDEX_BITS];
	assign lookup.tag = req_addr[icache_pkg::ADDR_BITS-1:TAG_LSB];
	assign lookup.word_sel = req_addr[icache_pkg::WORD_OFFSET_BITS +: 2];
	assign lookup.lookup_en = (state == icache_pkg::S_LOOKUP);
	assign lookup.fill_commit = (state == icache_pkg::S_REFILL) && fill.done;

	assign fill.start = miss;
	assign fill.line_addr = {req_addr[icache_pkg::ADDR_BITS-1:icache_pkg::OFFSET_BITS],
		{icache_pkg::OFFSET_BITS{1'b0}}};
	assign fill.fill_way = fill_way_q;

	always_comb begin
		next_state = state;
		case (state)
			icache_pkg::S_IDLE: begin
				if (req_take)
					next_state = icache_pkg::S_LOOKUP;
			end
			icache_pkg::S_LOOKUP: begin
				if (lookup.hit)
					next_state = icache_pkg::S_IDLE;
				else
					next_state = icache_pkg::S_REFILL;
			end
			icache_pkg::S_REFILL: begin
				if (fill.done)
					next_state = icache_pkg::S_LOOKUP; // lookup again, now hits
			end
			default: next_state = icache_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= icache_pkg::S_IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge clk) begin
		if (state == icache_pkg::S_IDLE && req_take)
			req_addr <= cpu_req_addr;
		if (miss)
			fill_way_q <= lookup.victim_way;
		if (lookup.lookup_en && lookup.hit)
			cpu_data_read <= lookup.rd_data; // holds until the next hit
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			cpu_ready <= 1'b0;
		else
			cpu_ready <= lookup.lookup_en && lookup.hit;
	end

endmodule

/* design/icache_refill.sv */
`timescale 1ns/100ps

module icache_refill (
	input logic clk,
	input logic rst_n,
	icache_fill_if.refill fill,
	output icache_pkg::addr_t mem_req_addr,
	output logic mem_req_valid,
	input icache_pkg::word_t mem_data_read,
	input logic mem_ready,
	input logic mem_done
);

	localparam icache_pkg::beat_t LAST_BEAT = icache_pkg::beat_t'(icache_pkg::BEATS_PER_LINE - 1);

	logic busy;
	icache_pkg::beat_t beat_cnt;
	logic beat_in;
	logic last_beat;

	assign beat_in = busy && mem_ready;
	// mem_done ends the burst, the count covers a missing done
	assign last_beat = mem_done || (beat_cnt == LAST_BEAT);

	// beats go straight into the array on the edge they arrive
	assign fill.beat_valid = beat_in;
	assign fill.beat_idx = beat_cnt;
	assign fill.beat_data = mem_data_read;

	always_ff @(posedge clk) begin
		if (fill.start)
			mem_req_addr <= {fill.line_addr[icache_pkg::ADDR_BITS-1:icache_pkg::OFFSET_BITS],
				{icache_pkg::OFFSET_BITS{1'b0}}};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			beat_cnt <= '0;
			mem_req_valid <= 1'b0;
			fill.done <= 1'b0;
		end else begin
			fill.done <= 1'b0;
			if (fill.start) begin
				busy <= 1'b1;
				beat_cnt <= '0;
				mem_req_valid <= 1'b1;
			end else if (beat_in) begin
				mem_req_valid <= 1'b0; // request taken with the first beat
				beat_cnt <= beat_cnt + 1'b1;
				if (last_beat) begin
					busy <= 1'b0;
					fill.done <= 1'b1;
				end
			end
		end
	end

endmodule

/* design/icache_data_array.sv */
`timescale 1ns/100ps

module icache_data_array #(
	parameter int NUM_SETS = 64
) (
	input logic clk,
	icache_lookup_if.data lookup,
	icache_fill_if.data fill
);

	// one line of four words per set and way
	icache_pkg::word_t line_mem [2][NUM_SETS][icache_pkg::BEATS_PER_LINE];

	always_ff @(posedge clk) begin
		if (fill.beat_valid)
			line_mem[fill.fill_way][lookup.index][fill.beat_idx] <= fill.beat_data;
	end

	// hit word, only meaningful while the tags report a hit
	assign lookup.rd_data = line_mem[lookup.hit_way][lookup.index][lookup.word_sel];

endmodule

/* design/icache_tag_array.sv */
`timescale 1ns/100ps

module icache_tag_array #(
	parameter int NUM_SETS = 64
) (
	input logic clk,
	input logic rst_n,
	input logic flush,
	icache_lookup_if.tags lookup,
	input icache_pkg::way_t fill_way
);

	localparam int INDEX_BITS = $clog2(NUM_SETS);
	localparam int TAG_BITS = icache_pkg::ADDR_BITS - icache_pkg::OFFSET_BITS - INDEX_BITS;

	logic [TAG_BITS-1:0] tag_mem [2][NUM_SETS];
	logic [1:0][NUM_SETS-1:0] valid; // per way, per set
	logic [NUM_SETS-1:0] lru; // most recently used way of each set

	logic [1:0] way_valid;
	logic [1:0] way_hit;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_valid[w] = valid[w][lookup.index];
			way_hit[w] = way_valid[w] && (tag_mem[w][lookup.index] == lookup.tag);
		end
	end

	assign lookup.hit = |way_hit;
	assign lookup.hit_way = icache_pkg::way_t'(way_hit[1]);

	// invalid way first, way 0 when both are free
	always_comb begin
		if (!way_valid[0])
			lookup.victim_way = 1'b0;
		else if (!way_valid[1])
			lookup.victim_way = 1'b1;
		else
			lookup.victim_way = ~lru[lookup.index];
	end

	always_ff @(posedge clk) begin
		if (lookup.fill_commit)
			tag_mem[fill_way][lookup.index] <= lookup.tag;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;
			lru <= '0;
		end else begin
			if (lookup.lookup_en && lookup.hit)
				lru[lookup.index] <= lookup.hit_way;
			if (lookup.fill_commit && !flush) begin
				valid[fill_way][lookup.index] <= 1'b1;
				lru[lookup.index] <= fill_way;
			end
			if (flush)
				valid <= '0; // fence.i, drops a commit in the same cycle
		end
	end

endmodule

/* design/icache_if.sv */
`timescale 1ns/100ps

interface icache_lookup_if #(
	parameter int NUM_SETS = 64
);
	localparam int INDEX_BITS = $clog2(NUM_SETS);
	localparam int TAG_BITS = icache_pkg::ADDR_BITS - icache_pkg::OFFSET_BITS - INDEX_BITS;

	logic [INDEX_BITS-1:0] index;
	logic [TAG_BITS-1:0] tag;
	icache_pkg::beat_t word_sel;
	logic lookup_en;
	logic fill_commit; // tag and valid write of the refilled way

	logic hit;
	icache_pkg::way_t hit_way;
	icache_pkg::way_t victim_way;
	icache_pkg::word_t rd_data; // word of hit_way at word_sel

	modport ctrl (
		output index, tag, word_sel, lookup_en, fill_commit,
		input hit, hit_way, victim_way, rd_data
	);

	modport tags (
		input index, tag, lookup_en, fill_commit,
		output hit, hit_way, victim_way
	);

	modport data (
		input index, word_sel, hit_way,
		output rd_data
	);

endinterface

interface icache_fill_if;
	logic start;
	icache_pkg::addr_t line_addr;
	icache_pkg::way_t fill_way;

	logic beat_valid;
	icache_pkg::beat_t beat_idx;
	icache_pkg::word_t beat_data;
	logic done;

	modport ctrl (output start, line_addr, fill_way, input done);
	modport refill (input start, line_addr, output beat_valid, beat_idx, beat_data, done);
	modport data (input fill_way, beat_valid, beat_idx, beat_data);

endinterface

/* design/icache_pkg.sv */
package icache_pkg;

	localparam int ADDR_BITS = 64;
	localparam int WORD_BITS = 64;

	typedef logic [ADDR_BITS-1:0] addr_t; // byte address
	typedef logic [WORD_BITS-1:0] word_t; // fetch word and memory beat
	typedef logic way_t;
	typedef logic [1:0] beat_t; // beat in line, also word select

	// line geometry, 32 byte lines of four 64-bit words
	localparam int OFFSET_BITS = 5;
	localparam int WORD_OFFSET_BITS = 3; // byte within a word
	localparam int BEATS_PER_LINE = 4;

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOOKUP,
		S_REFILL
	} cache_state_e;

endpackage
